// File: design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // geometry defaults that the top level may override for sets and ways.
    localparam int num_sets   = 4;
    localparam int num_ways   = 4;
    localparam int line_words = 16;

    // address split for the default geometry.
    localparam int tag_bits  = 24;  // bits 31..8.
    localparam int set_bits  = 2;   // bits 7..6.
    localparam int word_bits = 4;   // bits 5..2.

    // one access is in flight at a time.
    typedef enum logic [3:0] {
        idle,
        lookup,
        respond,
        wb_addr,        // victim line address out.
        wb_data,
        wb_resp,
        refill_addr,
        refill_data,
        install
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    localparam int addr_bits = 32;
    localparam int data_bits = 32;
    localparam int strb_bits = data_bits / 8;

    // fixed incrementing bursts of one full line.
    localparam int burst_beats = 16;

    typedef enum logic [1:0] {
        okay   = 2'b00,
        slverr = 2'b10
    } resp_t;

endpackage

`default_nettype wire

// File: design/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store #(
    parameter int num_sets = cache_pkg::num_sets,
    parameter int num_ways = cache_pkg::num_ways,
    localparam int set_w = $clog2(num_sets),
    localparam int way_w = $clog2(num_ways),
    localparam int tag_w = cache_pkg::tag_bits + cache_pkg::set_bits - set_w
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [mem_bus_pkg::addr_bits-1:0]   lookup_addr,
    input  logic                                install,
    input  logic                                install_dirty,
    input  logic                                mark_dirty,
    output logic                                hit,
    output logic [way_w-1:0]                    hit_way,
    output logic [way_w-1:0]                    victim_way,
    output logic                                victim_dirty,
    output logic [tag_w-1:0]                    victim_tag
);

    localparam int off_w = cache_pkg::word_bits + $clog2(mem_bus_pkg::strb_bits);

    logic [tag_w-1:0]    tags   [num_sets][num_ways];
    logic [num_ways-1:0] valid  [num_sets];
    logic [num_ways-1:0] dirty  [num_sets];
    logic [way_w-1:0]    rr_ptr [num_sets];   // next victim per set.

    logic [set_w-1:0]    set_idx;
    logic [tag_w-1:0]    lookup_tag;
    logic [num_ways-1:0] match;

    assign set_idx    = lookup_addr[off_w +: set_w];
    assign lookup_tag = lookup_addr[mem_bus_pkg::addr_bits-1 -: tag_w];

    // parallel compare across the ways of the indexed set.
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            match[w] = valid[set_idx][w] && (tags[set_idx][w] == lookup_tag);
            if (match[w]) begin
                hit_way = way_w'(w);
            end
        end
    end

    assign hit          = |match;
    assign victim_way   = rr_ptr[set_idx];
    assign victim_dirty = valid[set_idx][victim_way] && dirty[set_idx][victim_way];
    assign victim_tag   = tags[set_idx][victim_way];   // write-back address.

    always_ff @(posedge clk) begin
        if (install) begin
            tags[set_idx][victim_way] <= lookup_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s]  <= '0;
                dirty[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else if (install) begin
            valid[set_idx][victim_way] <= 1'b1;
            dirty[set_idx][victim_way] <= install_dirty;
            rr_ptr[set_idx]            <= rr_ptr[set_idx] + 1'b1;   // round robin.
        end else if (mark_dirty) begin
            dirty[set_idx][hit_way] <= 1'b1;
        end
    end

    // a tag lives in at most one way of its set.
    a_single_match: assert property (@(posedge clk) disable iff (reset)
        $onehot0(match));

    // the controller installs only after a miss, which keeps the line unique.
    a_install_on_miss: assert property (@(posedge clk) disable iff (reset)
        install |-> !hit);

endmodule

`default_nettype wire

// File: design/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store #(
    parameter int num_sets = cache_pkg::num_sets,
    parameter int num_ways = cache_pkg::num_ways,
    localparam int set_w = $clog2(num_sets),
    localparam int way_w = $clog2(num_ways)
) (
    input  logic                                clk,
    input  logic [set_w-1:0]                    set_idx,
    input  logic [way_w-1:0]                    way,
    input  logic [cache_pkg::word_bits-1:0]     word_idx,
    input  logic                                wr_en,
    input  logic [mem_bus_pkg::strb_bits-1:0]   wr_strb,
    input  logic [mem_bus_pkg::data_bits-1:0]   wr_data,
    output logic [mem_bus_pkg::data_bits-1:0]   rd_data
);

    localparam int depth  = num_sets * num_ways * cache_pkg::line_words;
    localparam int addr_w = $clog2(depth);

    // one word per entry, lines laid out as set, way, word.
    logic [mem_bus_pkg::data_bits-1:0] data_mem [depth];
    logic [addr_w-1:0]                 word_addr;

    assign word_addr = {set_idx, way, word_idx};

    // byte merge under the strobes.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < mem_bus_pkg::strb_bits; b++) begin
                if (wr_strb[b]) begin
                    data_mem[word_addr][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    assign rd_data = data_mem[word_addr];   // also feeds the write-back beat.

endmodule

`default_nettype wire

// File: design/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
    parameter int num_sets = cache_pkg::num_sets,
    parameter int num_ways = cache_pkg::num_ways,
    localparam int set_w = $clog2(num_sets),
    localparam int way_w = $clog2(num_ways),
    localparam int tag_w = cache_pkg::tag_bits + cache_pkg::set_bits - set_w
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [mem_bus_pkg::addr_bits-1:0]   req_addr,
    input  logic                                req_read,
    input  logic [mem_bus_pkg::strb_bits-1:0]   req_strb,
    input  logic [mem_bus_pkg::data_bits-1:0]   req_wdata,
    output logic [mem_bus_pkg::data_bits-1:0]   resp_rdata,
    output logic                                resp_rvalid,
    output logic                                resp_wdone,

    input  logic                                hit,
    input  logic [way_w-1:0]                    hit_way,
    input  logic [way_w-1:0]                    victim_way,
    input  logic                                victim_dirty,
    input  logic [tag_w-1:0]                    victim_tag,
    output logic                                install,
    output logic                                install_dirty,
    output logic                                mark_dirty,

    output logic [way_w-1:0]                    ls_way,
    output logic [cache_pkg::word_bits-1:0]     ls_word,
    output logic                                ls_wr_en,
    output logic [mem_bus_pkg::strb_bits-1:0]   ls_strb,
    output logic [mem_bus_pkg::data_bits-1:0]   ls_wdata,
    input  logic [mem_bus_pkg::data_bits-1:0]   ls_rdata,

    output logic [mem_bus_pkg::addr_bits-1:0]   awaddr,
    output logic                                awvalid,
    input  logic                                awready,
    output logic [mem_bus_pkg::data_bits-1:0]   wdata,
    output logic                                wlast,
    output logic                                wvalid,
    input  logic                                wready,
    input  logic                                bvalid,
    output logic                                bready,
    output logic [mem_bus_pkg::addr_bits-1:0]   araddr,
    output logic                                arvalid,
    input  logic                                arready,
    input  logic [mem_bus_pkg::data_bits-1:0]   rdata,
    input  logic                                rlast,
    input  logic                                rvalid,
    output logic                                rready
);

    localparam int off_w = cache_pkg::word_bits + $clog2(mem_bus_pkg::strb_bits);
    localparam logic [cache_pkg::word_bits-1:0] last_beat =
        cache_pkg::word_bits'(mem_bus_pkg::burst_beats - 1);

    cache_pkg::ctrl_state_t          state;
    logic [cache_pkg::word_bits-1:0] beat;      // shared by write-back and refill.
    logic                            is_write;
    logic                            req_pending;
    logic [set_w-1:0]                req_set;
    logic                            in_burst;

    assign is_write = |req_strb;
    assign req_set  = req_addr[off_w +: set_w];
    assign in_burst = (state == cache_pkg::wb_data) || (state == cache_pkg::refill_data);

    // the requester still holds the request in the cycle its response is up.
    assign req_pending = (req_read || is_write) && !resp_rvalid && !resp_wdone;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::idle;
            beat  <= '0;
        end else begin
            case (state)
                cache_pkg::idle: begin
                    if (req_pending) begin
                        state <= cache_pkg::lookup;
                    end
                end
                cache_pkg::lookup: begin
                    if (hit) begin
                        state <= cache_pkg::respond;
                    end else if (victim_dirty) begin
                        state <= cache_pkg::wb_addr;
                    end else begin
                        state <= cache_pkg::refill_addr;
                    end
                end
                cache_pkg::respond: state <= cache_pkg::idle;
                cache_pkg::wb_addr: begin
                    if (awready) begin
                        state <= cache_pkg::wb_data;
                        beat  <= '0;
                    end
                end
                cache_pkg::wb_data: begin
                    if (wvalid && wready) begin
                        beat <= beat + 1'b1;
                        if (beat == last_beat) begin
                            state <= cache_pkg::wb_resp;
                        end
                    end
                end
                cache_pkg::wb_resp: begin
                    if (bvalid) begin
                        state <= cache_pkg::refill_addr;   // bresp ignored.
                    end
                end
                cache_pkg::refill_addr: begin
                    if (arready) begin
                        state <= cache_pkg::refill_data;
                        beat  <= '0;
                    end
                end
                cache_pkg::refill_data: begin
                    if (rvalid) begin
                        beat <= beat + 1'b1;
                        if (rlast) begin
                            state <= cache_pkg::install;
                        end
                    end
                end
                cache_pkg::install: state <= cache_pkg::lookup;   // replay as a hit.
                default: state <= cache_pkg::idle;
            endcase
        end
    end

    // one-cycle response pulses.
    always_ff @(posedge clk) begin
        if (reset) begin
            resp_rvalid <= 1'b0;
            resp_wdone  <= 1'b0;
        end else begin
            resp_rvalid <= (state == cache_pkg::respond) && req_read;
            resp_wdone  <= (state == cache_pkg::respond) && is_write;
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_pkg::respond && req_read) begin
            resp_rdata <= ls_rdata;
        end
    end

    // tag side.
    assign install       = (state == cache_pkg::install);
    assign install_dirty = is_write;
    assign mark_dirty    = (state == cache_pkg::respond) && is_write;

    // the victim way stays stable until install moves the pointer.
    assign ls_way   = (state == cache_pkg::respond) ? hit_way : victim_way;
    assign ls_word  = in_burst ? beat : req_addr[2 +: cache_pkg::word_bits];
    assign ls_wr_en = ((state == cache_pkg::respond) && is_write) ||
                      ((state == cache_pkg::refill_data) && rvalid);
    assign ls_strb  = (state == cache_pkg::refill_data) ?
                      {mem_bus_pkg::strb_bits{1'b1}} : req_strb;
    assign ls_wdata = (state == cache_pkg::refill_data) ? rdata : req_wdata;

    // memory side.
    assign awvalid = (state == cache_pkg::wb_addr);
    assign awaddr  = {victim_tag, req_set, {off_w{1'b0}}};
    assign wvalid  = (state == cache_pkg::wb_data);
    assign wdata   = ls_rdata;
    assign wlast   = wvalid && (beat == last_beat);
    assign bready  = 1'b1;
    assign arvalid = (state == cache_pkg::refill_addr);
    assign araddr  = {req_addr[mem_bus_pkg::addr_bits-1:off_w], {off_w{1'b0}}};
    assign rready  = 1'b1;

    a_aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr));

    a_ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr));

    // both bursts close on beat 15 of the shared counter.
    a_last_beat: assert property (@(posedge clk) disable iff (reset)
        (wlast || (state == cache_pkg::refill_data && rvalid && rlast)) |->
        beat == last_beat);

    a_one_resp: assert property (@(posedge clk) disable iff (reset)
        !(resp_rvalid && resp_wdone));

endmodule

`default_nettype wire

// File: design/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int num_sets = cache_pkg::num_sets,
    parameter int num_ways = cache_pkg::num_ways
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [mem_bus_pkg::addr_bits-1:0]   req_addr,
    input  logic                                req_read,
    input  logic [mem_bus_pkg::strb_bits-1:0]   req_strb,
    input  logic [mem_bus_pkg::data_bits-1:0]   req_wdata,
    output logic [mem_bus_pkg::data_bits-1:0]   resp_rdata,
    output logic                                resp_rvalid,
    output logic                                resp_wdone,

    output logic [mem_bus_pkg::addr_bits-1:0]   awaddr,
    output logic                                awvalid,
    input  logic                                awready,
    output logic [mem_bus_pkg::data_bits-1:0]   wdata,
    output logic                                wlast,
    output logic                                wvalid,
    input  logic                                wready,
    input  logic                                bvalid,
    output logic                                bready,
    output logic [mem_bus_pkg::addr_bits-1:0]   araddr,
    output logic                                arvalid,
    input  logic                                arready,
    input  logic [mem_bus_pkg::data_bits-1:0]   rdata,
    input  logic                                rlast,
    input  logic                                rvalid,
    output logic                                rready
);

    localparam int set_w = $clog2(num_sets);
    localparam int way_w = $clog2(num_ways);
    localparam int tag_w = cache_pkg::tag_bits + cache_pkg::set_bits - set_w;
    localparam int off_w = cache_pkg::word_bits + $clog2(mem_bus_pkg::strb_bits);

    logic                              hit;
    logic [way_w-1:0]                  hit_way;
    logic [way_w-1:0]                  victim_way;
    logic                              victim_dirty;
    logic [tag_w-1:0]                  victim_tag;
    logic                              install;
    logic                              install_dirty;
    logic                              mark_dirty;
    logic [set_w-1:0]                  ls_set;
    logic [way_w-1:0]                  ls_way;
    logic [cache_pkg::word_bits-1:0]   ls_word;
    logic                              ls_wr_en;
    logic [mem_bus_pkg::strb_bits-1:0] ls_strb;
    logic [mem_bus_pkg::data_bits-1:0] ls_wdata;
    logic [mem_bus_pkg::data_bits-1:0] ls_rdata;

    assign ls_set = req_addr[off_w +: set_w];   // request is held for the whole access.

    tag_store #(.num_sets(num_sets), .num_ways(num_ways)) tag_store_inst (
        .clk(clk), .reset(reset), .lookup_addr(req_addr),
        .install(install), .install_dirty(install_dirty), .mark_dirty(mark_dirty),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag)
    );

    line_store #(.num_sets(num_sets), .num_ways(num_ways)) line_store_inst (
        .clk(clk), .set_idx(ls_set), .way(ls_way), .word_idx(ls_word),
        .wr_en(ls_wr_en), .wr_strb(ls_strb), .wr_data(ls_wdata), .rd_data(ls_rdata)
    );

    cache_ctrl #(.num_sets(num_sets), .num_ways(num_ways)) cache_ctrl_inst (
        .clk(clk), .reset(reset),
        .req_addr(req_addr), .req_read(req_read), .req_strb(req_strb),
        .req_wdata(req_wdata), .resp_rdata(resp_rdata),
        .resp_rvalid(resp_rvalid), .resp_wdone(resp_wdone),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .install(install), .install_dirty(install_dirty), .mark_dirty(mark_dirty),
        .ls_way(ls_way), .ls_word(ls_word), .ls_wr_en(ls_wr_en),
        .ls_strb(ls_strb), .ls_wdata(ls_wdata), .ls_rdata(ls_rdata),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready)
    );

endmodule

`default_nettype wire

// File: dv/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
    parameter int          mem_words = 4096,
    parameter logic [31:0] seed      = 32'h1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready
);

    localparam int idx_w = $clog2(mem_words);

    logic [31:0]      mem [mem_words];
    logic [31:0]      rnd;
    logic             wr_active;
    logic             b_pending;   // burst done, response not yet offered.
    logic             rd_active;
    logic [idx_w-1:0] wr_idx;
    logic [idx_w-1:0] rd_idx;
    logic [3:0]       rd_beat;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // each word holds its own byte address xor a marker.
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 32'(i << 2) ^ 32'h5a5a_0000;
        end
        rnd       = seed;
        wr_active = 1'b0;
        b_pending = 1'b0;
        bvalid    = 1'b0;
        rd_active = 1'b0;
        rvalid    = 1'b0;
        wr_idx    = '0;
        rd_idx    = '0;
        rd_beat   = '0;
    end

    // upper lcg bits pick the stalls.
    assign awready = !wr_active && !b_pending && !bvalid && rnd[31];
    assign wready  = wr_active && (rnd[30] || rnd[29]);
    assign arready = !rd_active && rnd[28];
    assign rdata   = mem[rd_idx];
    assign rlast   = rvalid && (rd_beat == 4'd15);

    always @(posedge clk) begin
        rnd <= reset ? seed : next_rand(rnd);
    end

    always @(posedge clk) begin
        if (reset) begin
            wr_active <= 1'b0;
            b_pending <= 1'b0;
            bvalid    <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                wr_active <= 1'b1;
                wr_idx    <= awaddr[idx_w+1:2];
            end
            if (wvalid && wready) begin
                mem[wr_idx] <= wdata;
                wr_idx      <= wr_idx + idx_w'(1);
                if (wlast) begin
                    wr_active <= 1'b0;
                    b_pending <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (b_pending && rnd[25]) begin
                bvalid    <= 1'b1;
                b_pending <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            rd_active <= 1'b0;
            rvalid    <= 1'b0;
        end else if (arvalid && arready) begin
            rd_active <= 1'b1;
            rd_idx    <= araddr[idx_w+1:2];
            rd_beat   <= 4'd0;
        end else if (rvalid && rready) begin
            rd_idx    <= rd_idx + idx_w'(1);
            rd_beat   <= rd_beat + 4'd1;
            rvalid    <= !rlast && rnd[27];
            rd_active <= !rlast;
        end else if (rd_active) begin
            rvalid <= rvalid || rnd[27] || rnd[26];   // held once offered.
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    localparam int          clk_period   = 4;
    localparam int          mem_words    = 4096;   // 16 KB behind the cache.
    localparam int          idx_w        = $clog2(mem_words);
    localparam logic [31:0] seed         = 32'h2856_18cc;
    localparam int          num_directed = 11;
    localparam int          num_random   = 40;
    localparam int          num_entries  = num_directed + num_random;
    localparam int          hit_cycles   = 4;   // drive edge to the edge that sees the pulse.
    localparam int          watchdog_ns  = 4000 * num_entries * clk_period;

    typedef enum logic [1:0] {op_read, op_write, op_mem} op_t;

    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] data;
        logic        hit;   // must hit without a refill.
        logic [31:0] exp;
    } entry_t;

    logic        clk;
    logic        reset;
    logic [31:0] req_addr;
    logic        req_read;
    logic [3:0]  req_strb;
    logic [31:0] req_wdata;
    logic [31:0] resp_rdata;
    logic        resp_rvalid;
    logic        resp_wdone;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;

    entry_t      stim [num_entries];
    logic [31:0] shadow [mem_words];
    int          n_fill;
    int          errors;
    int          checks;
    logic [31:0] rnd;

    dcache_top dcache_top_inst (.*);

    axi_mem_model #(.mem_words(mem_words), .seed(seed)) axi_mem_model_inst (.*);

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        return 32'((tag << 8) | (set << 6) | (word << 2));
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
        end
        return result;
    endfunction

    task automatic add_entry(input op_t op, input logic [31:0] addr, input logic [3:0] strb,
                             input logic [31:0] data, input logic hit);
        stim[n_fill] = '{op, addr, strb, data, hit, 32'h0};
        n_fill++;
    endtask

    task automatic build_stimulus();
        logic [31:0] addr;
        logic [3:0]  strb;
        n_fill = 0;
        add_entry(op_read, make_addr(1, 0, 1), 4'h0, 32'h0, 1'b0);   // cold miss.
        add_entry(op_read, make_addr(1, 0, 2), 4'h0, 32'h0, 1'b1);
        add_entry(op_write, make_addr(1, 0, 1), 4'b0101, 32'hdead_beef, 1'b1);
        add_entry(op_read, make_addr(1, 0, 1), 4'h0, 32'h0, 1'b1);
        for (int t = 2; t <= 5; t++) begin   // tag 5 pushes tag 1 out of set 0.
            add_entry(op_write, make_addr(t, 0, 0), 4'hf, 32'h1111_0000 | 32'(t), 1'b0);
        end
        add_entry(op_mem, make_addr(1, 0, 1), 4'h0, 32'h0, 1'b0);
        add_entry(op_mem, make_addr(1, 0, 2), 4'h0, 32'h0, 1'b0);
        add_entry(op_read, make_addr(1, 0, 1), 4'h0, 32'h0, 1'b0);
        rnd = seed;
        for (int k = 0; k < num_random; k++) begin
            rnd  = next_rand(rnd);
            addr = make_addr(6 + int'(rnd[31:30]) % 3, int'(rnd[29:28]), int'(rnd[27:24]));
            strb = (rnd[23:20] == 4'h0) ? 4'hf : rnd[23:20];
            rnd  = next_rand(rnd);
            if (rnd[31]) add_entry(op_write, addr, strb, rnd, 1'b0);
            else add_entry(op_read, addr, 4'h0, 32'h0, 1'b0);
        end
    endtask

    // walk the table through the shadow to get each expected word.
    task automatic predict();
        logic [idx_w-1:0] idx;
        for (int i = 0; i < mem_words; i++) shadow[i] = 32'(i << 2) ^ 32'h5a5a_0000;
        for (int i = 0; i < num_entries; i++) begin
            idx = stim[i].addr[idx_w+1:2];
            if (stim[i].op == op_write) begin
                shadow[idx] = merge_bytes(shadow[idx], stim[i].data, stim[i].strb);
            end
            stim[i].exp = shadow[idx];
        end
    endtask

    task automatic check_low(input string name, input logic value);
        checks++;
        assert (value === 1'b0) else begin
            errors++;
            $display("Fail t=%0t %s expected 0 got %b", $time, name, value);
        end
    endtask

    task automatic run_access(input int i);
        int   cycles;
        logic saw_ar;
        cycles = 0;
        saw_ar = 1'b0;
        req_addr  <= stim[i].addr;
        req_read  <= (stim[i].op == op_read);
        req_strb  <= (stim[i].op == op_write) ? stim[i].strb : 4'h0;
        req_wdata <= stim[i].data;
        do begin
            @(posedge clk);
            cycles++;
            saw_ar = saw_ar | arvalid;
        end while (!resp_rvalid && !resp_wdone);
        checks++;
        if (stim[i].op == op_read) begin
            assert (resp_rvalid) else begin
                errors++;
                $display("entry %0d: a read was answered as a write", i);
            end
            assert (resp_rdata === stim[i].exp) else begin
                errors++;
                $display("Fail t=%0t entry %0d resp_rdata expected %h got %h",
                         $time, i, stim[i].exp, resp_rdata);
            end
        end else begin
            assert (resp_wdone) else begin
                errors++;
                $display("entry %0d: a write was answered as a read", i);
            end
        end
        if (stim[i].hit) begin
            assert (cycles == hit_cycles && !saw_ar) else begin
                errors++;
                $display("Fail t=%0t entry %0d hit latency expected %0d got %0d, arvalid seen %b",
                         $time, i, hit_cycles, cycles, saw_ar);
            end
        end
        req_read <= 1'b0;
        req_strb <= 4'h0;
        @(posedge clk);
        check_low("resp_rvalid", resp_rvalid);   // pulse lasts one cycle.
        check_low("resp_wdone", resp_wdone);
    endtask

    task automatic check_mem(input int i);
        logic [31:0] got;
        got = axi_mem_model_inst.mem[stim[i].addr[idx_w+1:2]];
        checks++;
        assert (got === stim[i].exp) else begin
            errors++;
            $display("Fail t=%0t mem[%h] expected %h got %h", $time, stim[i].addr,
                     stim[i].exp, got);
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        req_addr  = '0;
        req_read  = 1'b0;
        req_strb  = '0;
        req_wdata = '0;
        errors    = 0;
        checks    = 0;
        build_stimulus();
        predict();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_low("resp_rvalid", resp_rvalid);
        check_low("resp_wdone", resp_wdone);
        check_low("awvalid", awvalid);
        check_low("wvalid", wvalid);
        check_low("arvalid", arvalid);
        for (int i = 0; i < num_entries; i++) begin
            if (stim[i].op == op_mem) check_mem(i);
            else run_access(i);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the cache stopped answering", watchdog_ns);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
design/cache_pkg.sv
design/mem_bus_pkg.sv
design/tag_store.sv
design/line_store.sv
design/cache_ctrl.sv
design/dcache_top.sv
dv/axi_mem_model.sv
dv/tb_dcache.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_dcache
FILELIST  := sim.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := STATUS: PASS
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
